/* common/cart_pkg.sv */
// Shared widths, layout codes, header offsets and type codes used by every cartridge block
`default_nettype none

package cart_pkg;

	// ==============================
	// ROM download
	// ==============================
	localparam int ROM_ADDR_W = 24;
	localparam int WORD_W     = 16;

	// Copier header, stripped as filesize modulo 1024
	localparam int HDR_BYTES = 512;

	// Memory layout selected by the user
	typedef enum logic [1:0] {
		LOROM   = 2'd0,
		HIROM   = 2'd1,
		EXHIROM = 2'd2
	} rom_layout_t;

	// ==============================
	// Internal header
	// ==============================
	// Word offsets inside the 15-bit header window
	localparam logic [14:0] HDR_MAPPER_OFS = 15'h7FD4;
	localparam logic [14:0] HDR_TYPE_OFS   = 15'h7FD6;
	localparam logic [14:0] HDR_RAMSZ_OFS  = 15'h7FD8;
	localparam logic [14:0] HDR_MAKER_OFS  = 15'h7FDA;

	// Coprocessor class, upper nibble of the type code
	typedef enum logic [3:0] {
		CHIP_NONE = 4'h0,
		CHIP_SDD1 = 4'h5,
		CHIP_SA1  = 4'h6,
		CHIP_GSU  = 4'h7,
		CHIP_DSP1 = 4'h8,
		CHIP_DSP2 = 4'h9,
		CHIP_DSP3 = 4'hA,
		CHIP_DSP4 = 4'hB,
		CHIP_OBC1 = 4'hC
	} chip_class_t;

	// Class in 7:4, ST01x flag in bit 3, layout in 1:0
	typedef logic [7:0] rom_type_t;

	localparam int ST_FLAG_BIT = 3;

	// ==============================
	// Save RAM transfer
	// ==============================
	localparam int SECTOR_BYTES = 512;
	localparam int LBA_W        = 32;
	localparam int SAV_SIZE_W   = 12;

endpackage

`default_nettype wire

/* cart/rom_load_port.sv */
// Turns the download word stream into toggled ROM write requests with the copier header removed
`timescale 1ns/1ps
`default_nettype none

module rom_load_port #(
	parameter int ROM_ADDR_W = cart_pkg::ROM_ADDR_W
) (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         ioctl_download,
	input  wire                         ioctl_wr,
	input  wire [ROM_ADDR_W:0]          ioctl_addr,
	input  wire [cart_pkg::WORD_W-1:0]  ioctl_dout,
	input  wire [ROM_ADDR_W-1:0]        ioctl_filesize,
	output logic                        rom_req,
	output logic [ROM_ADDR_W-2:0]       rom_addr,
	output logic [cart_pkg::WORD_W-1:0] rom_data,
	output logic                        word_strobe,
	output logic [ROM_ADDR_W-1:0]       adj_addr
);

	import cart_pkg::*;

	// Bits of the file size that hold the copier header length
	localparam int STRIP_W = $clog2(2 * HDR_BYTES);

	logic                wr_en;
	logic [ROM_ADDR_W:0] addr_strip;

	assign wr_en = ioctl_download & ioctl_wr;

	// A 512-byte header leaves filesize mod 1024 nonzero
	assign addr_strip = ioctl_addr
		- {{(ROM_ADDR_W + 1 - STRIP_W){1'b0}}, ioctl_filesize[STRIP_W-1:0]};

	// Request toggle and strobe to the header detector
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_req     <= 1'b0;
			word_strobe <= 1'b0;
		end else begin
			word_strobe <= wr_en;
			if (wr_en)
				rom_req <= ~rom_req;
		end
	end

	// Address and data held until the next toggle
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			rom_addr <= addr_strip[ROM_ADDR_W-1:1];
			rom_data <= ioctl_dout;
			adj_addr <= addr_strip[ROM_ADDR_W-1:0];
		end
	end

endmodule

`default_nettype wire

/* cart/header_detect.sv */
// Captures the internal cartridge header during download and derives type code, masks and region
`timescale 1ns/1ps
`default_nettype none

module header_detect (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire                             word_strobe,
	input  wire [cart_pkg::ROM_ADDR_W-1:0]  adj_addr,
	input  wire [cart_pkg::WORD_W-1:0]      ioctl_data,
	input  wire                             ioctl_download,
	input  var cart_pkg::rom_layout_t       rom_layout,
	input  wire                             video_region,
	output cart_pkg::rom_type_t             rom_type,
	output logic [cart_pkg::ROM_ADDR_W-1:0] rom_mask,
	output logic [cart_pkg::ROM_ADDR_W-1:0] ram_mask,
	output logic                            pal
);

	import cart_pkg::*;

	localparam logic [ROM_ADDR_W-1:0] KIB = ROM_ADDR_W'(1024);

	rom_layout_t           layout_q;
	logic                  download_d;
	logic                  download_rise;
	logic [ROM_ADDR_W-1:0] hdr_base;

	// Raw header fields
	logic [7:0] mapper_hdr;
	logic [7:0] type_hdr;
	logic [3:0] rom_size;
	logic [3:0] ram_size;
	logic [7:0] maker_hdr;

	rom_type_t             type_next;
	logic [ROM_ADDR_W-1:0] rom_mask_next;
	logic [ROM_ADDR_W-1:0] ram_mask_next;

	assign download_rise = ioctl_download & ~download_d;

	// Layout is sampled once per download
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d <= 1'b0;
			layout_q   <= LOROM;
		end else begin
			download_d <= ioctl_download;
			if (download_rise)
				layout_q <= rom_layout;
		end
	end

	always_comb begin
		case (layout_q)
			HIROM:   hdr_base = ROM_ADDR_W'(24'h008000);
			EXHIROM: hdr_base = ROM_ADDR_W'(24'h408000);
			default: hdr_base = '0;
		endcase
	end

	// ==============================
	// Field capture
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (download_rise) begin
			mapper_hdr <= '0;
			type_hdr   <= '0;
			rom_size   <= '0;
			ram_size   <= '0;
			maker_hdr  <= '0;
		end else if (word_strobe) begin
			if (adj_addr == (hdr_base | ROM_ADDR_W'(HDR_MAPPER_OFS)))
				mapper_hdr <= ioctl_data[15:8];
			if (adj_addr == (hdr_base | ROM_ADDR_W'(HDR_TYPE_OFS)))
				{rom_size, type_hdr} <= ioctl_data[11:0];
			if (adj_addr == (hdr_base | ROM_ADDR_W'(HDR_RAMSZ_OFS)))
				ram_size <= ioctl_data[3:0];
			if (adj_addr == (hdr_base | ROM_ADDR_W'(HDR_MAKER_OFS)))
				maker_hdr <= ioctl_data[7:0];
		end
	end

	// ==============================
	// Classification
	// ==============================
	always_comb begin
		// Tiny size codes are treated as a 4 MiB image
		rom_mask_next = (KIB << ((rom_size < 4'd7) ? 4'd12 : rom_size)) - 1'b1;
		ram_mask_next = (ram_size != 4'd0) ? (KIB << ram_size) - 1'b1 : '0;
		type_next     = {6'd0, layout_q};

		if (mapper_hdr == 8'h30 && type_hdr == 8'h05 && maker_hdr == 8'hB2) begin
			type_next[7:4] = CHIP_DSP3;
		end else if (((mapper_hdr == 8'h20 || mapper_hdr == 8'h21) && type_hdr == 8'h03)
				|| (mapper_hdr == 8'h30 && type_hdr == 8'h05)
				|| (mapper_hdr == 8'h31 && (type_hdr == 8'h03 || type_hdr == 8'h05))) begin
			// DSP1 only raises bit 7
			type_next[7] = 1'b1;
		end else if (mapper_hdr == 8'h20 && type_hdr == 8'h05) begin
			type_next[7:4] = CHIP_DSP2;
		end else if (mapper_hdr == 8'h30 && type_hdr == 8'h03) begin
			type_next[7:4] = CHIP_DSP4;
		end else if (mapper_hdr == 8'h30 && type_hdr == 8'h25) begin
			type_next[7:4] = CHIP_OBC1;
		end else if (mapper_hdr == 8'h32 && (type_hdr == 8'h43 || type_hdr == 8'h45)) begin
			type_next[7:4] = CHIP_SDD1;
		end else if (mapper_hdr == 8'h30 && type_hdr == 8'hF6) begin
			type_next[7:4]        = 4'h8;
			type_next[ST_FLAG_BIT] = 1'b1;
			// Small ST01x images use the other variant
			if (rom_size < 4'd10)
				type_next[5] = 1'b1;
		end else if (mapper_hdr == 8'h20 && (type_hdr == 8'h13 || type_hdr == 8'h14
				|| type_hdr == 8'h15 || type_hdr == 8'h1A)) begin
			type_next[7:4] = CHIP_GSU;
			ram_mask_next  = (KIB << 4'd6) - 1'b1;
		end else if (mapper_hdr == 8'h23 && (type_hdr == 8'h32 || type_hdr == 8'h34
				|| type_hdr == 8'h35)) begin
			type_next[7:4] = CHIP_SA1;
		end
	end

	// Outputs follow the header only outside download
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_type <= '0;
			rom_mask <= '0;
			ram_mask <= '0;
			pal      <= 1'b0;
		end else if (!ioctl_download) begin
			rom_type <= type_next;
			rom_mask <= rom_mask_next;
			ram_mask <= ram_mask_next;
			pal      <= video_region;
		end
	end

endmodule

`default_nettype wire

/* backup/backup_sequencer.sv */
// Moves battery-backed save RAM between SD sectors and backup memory on mount and on save request
`timescale 1ns/1ps
`default_nettype none

module backup_sequencer #(
	parameter int BRAM_ADDR_W = 19
) (
	input  wire                                          clk_sys,
	input  wire                                          reset,
	input  wire                                          ioctl_download,
	input  wire                                          img_mounted,
	input  wire [cart_pkg::LBA_W-1:0]                    img_size,
	input  wire                                          save_trigger,
	input  wire                                          sd_ack,
	input  wire [$clog2(cart_pkg::SECTOR_BYTES)-1:0]     sd_buff_addr,
	input  wire [7:0]                                    sd_buff_dout,
	input  wire                                          sd_buff_wr,
	input  wire                                          sd_buff_rd,
	input  wire [cart_pkg::WORD_W-1:0]                   bram_rdata,
	output logic [cart_pkg::LBA_W-1:0]                   sd_lba,
	output logic                                         sd_rd,
	output logic                                         sd_wr,
	output logic [7:0]                                   sd_buff_din,
	output logic                                         bram_req,
	output logic [BRAM_ADDR_W-1:0]                       bram_addr,
	output logic [cart_pkg::WORD_W-1:0]                  bram_wdata,
	output logic                                         bram_we,
	output logic                                         halt,
	output logic                                         activity_led
);

	import cart_pkg::*;

	localparam int SECTOR_SHIFT = $clog2(SECTOR_BYTES);

	typedef enum logic {
		ST_IDLE,
		ST_XFER
	} bk_state_t;

	bk_state_t             state;
	logic                  bk_ena;
	logic                  bk_load;
	logic [SAV_SIZE_W-1:0] last_sector;
	logic [WORD_W-1:0]     rd_word;

	// Edge detectors
	logic mounted_d;
	logic download_d;
	logic load_d;
	logic save_d;
	logic ack_d;

	logic mount_rise;
	logic start_load;
	logic start_save;
	logic start_xfer;
	logic ack_fall;
	logic last_done;

	assign mount_rise = img_mounted & ~mounted_d;
	assign start_load = bk_ena & bk_load & ~load_d;
	assign start_save = bk_ena & save_trigger & ~save_d & ~start_load;
	assign start_xfer = (state == ST_IDLE) & (start_load | start_save);
	assign ack_fall   = ack_d & ~sd_ack;
	assign last_done  = (sd_lba[SAV_SIZE_W-1:0] == last_sector);

	// ==============================
	// Control
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= ST_IDLE;
			bk_ena     <= 1'b0;
			bk_load    <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bram_req   <= 1'b0;
			mounted_d  <= 1'b0;
			download_d <= 1'b0;
			load_d     <= 1'b0;
			save_d     <= 1'b0;
			ack_d      <= 1'b0;
		end else begin
			mounted_d  <= img_mounted;
			download_d <= ioctl_download;
			load_d     <= bk_load;
			save_d     <= save_trigger;
			ack_d      <= sd_ack;

			// Empty image turns save RAM off
			if (mount_rise) begin
				if (img_size != '0) begin
					bk_ena  <= 1'b1;
					bk_load <= 1'b1;
				end else begin
					bk_ena <= 1'b0;
				end
			end

			if (ioctl_download && !download_d)
				bk_ena <= 1'b0;

			// SD side has taken the request
			if (sd_ack && !ack_d) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				ST_IDLE: begin
					if (start_xfer) begin
						state <= ST_XFER;
						sd_rd <= start_load;
						sd_wr <= start_save;
						// Fetch word 0 ahead of the first read strobe
						if (start_save)
							bram_req <= ~bram_req;
					end
				end
				ST_XFER: begin
					if (ack_fall) begin
						if (last_done) begin
							bk_load <= 1'b0;
							state   <= ST_IDLE;
						end else begin
							sd_rd <= bk_load;
							sd_wr <= ~bk_load;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase

			// One request per completed or consumed word
			if ((sd_buff_wr || sd_buff_rd) && sd_buff_addr[0])
				bram_req <= ~bram_req;
		end
	end

	// ==============================
	// Sector and word datapath
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (mount_rise && img_size != '0)
			last_sector <= img_size[SECTOR_SHIFT +: SAV_SIZE_W];

		if (start_xfer) begin
			sd_lba <= '0;
			// Load starts one below zero so the first word lands at 0
			bram_addr <= start_save ? '0 : '1;
		end else if (state == ST_XFER && ack_fall && !last_done) begin
			sd_lba <= sd_lba + 1'b1;
		end

		// Little-endian pairs from the SD buffer
		if (sd_buff_wr) begin
			if (sd_buff_addr[0]) begin
				bram_wdata[15:8] <= sd_buff_dout;
				bram_addr        <= bram_addr + 1'b1;
			end else begin
				bram_wdata[7:0] <= sd_buff_dout;
			end
		end

		if (sd_buff_rd && sd_buff_addr[0])
			bram_addr <= bram_addr + 1'b1;

		// Hold the fetched word while its odd byte goes out
		if (!sd_buff_addr[0])
			rd_word <= bram_rdata;
	end

	assign sd_buff_din  = sd_buff_addr[0] ? rd_word[15:8] : rd_word[7:0];
	assign bram_we      = bk_load;
	assign halt         = (state == ST_XFER);
	assign activity_led = ~(bk_ena | ioctl_download);

endmodule

`default_nettype wire

/* logic/cart_subsystem_top.sv */
// Cartridge side of the console top level, joining ROM download, header detection and save RAM
`timescale 1ns/1ps
`default_nettype none

module cart_subsystem_top #(
	parameter int BRAM_ADDR_W = 19
) (
	input  wire                                      clk_sys,
	input  wire                                      reset,
	input  wire                                      ioctl_download,
	input  wire                                      ioctl_wr,
	input  wire [cart_pkg::ROM_ADDR_W:0]             ioctl_addr,
	input  wire [cart_pkg::WORD_W-1:0]               ioctl_dout,
	input  wire [cart_pkg::ROM_ADDR_W-1:0]           ioctl_filesize,
	input  var cart_pkg::rom_layout_t                rom_layout,
	input  wire                                      video_region,
	input  wire                                      img_mounted,
	input  wire [cart_pkg::LBA_W-1:0]                img_size,
	input  wire                                      save_trigger,
	input  wire                                      sd_ack,
	input  wire [$clog2(cart_pkg::SECTOR_BYTES)-1:0] sd_buff_addr,
	input  wire [7:0]                                sd_buff_dout,
	input  wire                                      sd_buff_wr,
	input  wire                                      sd_buff_rd,
	input  wire [cart_pkg::WORD_W-1:0]               bram_rdata,
	output wire                                      rom_req,
	output wire [cart_pkg::ROM_ADDR_W-2:0]           rom_addr,
	output wire [cart_pkg::WORD_W-1:0]               rom_data,
	output wire cart_pkg::rom_type_t                 rom_type,
	output wire [cart_pkg::ROM_ADDR_W-1:0]           rom_mask,
	output wire [cart_pkg::ROM_ADDR_W-1:0]           ram_mask,
	output wire                                      pal,
	output wire [cart_pkg::LBA_W-1:0]                sd_lba,
	output wire                                      sd_rd,
	output wire                                      sd_wr,
	output wire [7:0]                                sd_buff_din,
	output wire                                      bram_req,
	output wire [BRAM_ADDR_W-1:0]                    bram_addr,
	output wire [cart_pkg::WORD_W-1:0]               bram_wdata,
	output wire                                      bram_we,
	output wire                                      halt,
	output wire                                      activity_led
);

	import cart_pkg::*;

	// Download word handed on to the header detector
	logic                  word_strobe;
	logic [ROM_ADDR_W-1:0] adj_addr;

	rom_load_port #(
		.ROM_ADDR_W(ROM_ADDR_W)
	) u_rom_load_port (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_filesize (ioctl_filesize),
		.rom_req        (rom_req),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data),
		.word_strobe    (word_strobe),
		.adj_addr       (adj_addr)
	);

	header_detect u_header_detect (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.word_strobe    (word_strobe),
		.adj_addr       (adj_addr),
		.ioctl_data     (rom_data),
		.ioctl_download (ioctl_download),
		.rom_layout     (rom_layout),
		.video_region   (video_region),
		.rom_type       (rom_type),
		.rom_mask       (rom_mask),
		.ram_mask       (ram_mask),
		.pal            (pal)
	);

	backup_sequencer #(
		.BRAM_ADDR_W(BRAM_ADDR_W)
	) u_backup_sequencer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.img_mounted    (img_mounted),
		.img_size       (img_size),
		.save_trigger   (save_trigger),
		.sd_ack         (sd_ack),
		.sd_buff_addr   (sd_buff_addr),
		.sd_buff_dout   (sd_buff_dout),
		.sd_buff_wr     (sd_buff_wr),
		.sd_buff_rd     (sd_buff_rd),
		.bram_rdata     (bram_rdata),
		.sd_lba         (sd_lba),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.sd_buff_din    (sd_buff_din),
		.bram_req       (bram_req),
		.bram_addr      (bram_addr),
		.bram_wdata     (bram_wdata),
		.bram_we        (bram_we),
		.halt           (halt),
		.activity_led   (activity_led)
	);

endmodule

`default_nettype wire

/* verif/tb_ref_model.svh */
// Reference functions for the cartridge testbench, included inside the testbench module
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	logic fb;
	fb = s[15] ^ s[13] ^ s[12] ^ s[10];
	return {s[14:0], fb};
endfunction

// ROM word address after removing the copier header
function automatic logic [22:0] stripped_word_addr(input logic [24:0] file_addr,
		input logic [23:0] fsize);
	logic [24:0] stripped;
	stripped = file_addr - {15'd0, fsize[9:0]};
	return stripped[23:1];
endfunction

function automatic logic [23:0] header_window_base(input logic [1:0] layout);
	case (layout)
		2'd1:    return 24'h008000;
		2'd2:    return 24'h408000;
		default: return 24'h000000;
	endcase
endfunction

function automatic logic [23:0] rom_mask_for_size(input logic [3:0] rs);
	logic [23:0] kib;
	kib = 24'd1024;
	if (rs < 4'd7)
		return (kib << 12) - 24'd1;
	return (kib << rs) - 24'd1;
endfunction

function automatic logic [23:0] ram_mask_for_header(input logic [7:0] mapper,
		input logic [7:0] typ, input logic [3:0] ras);
	logic [23:0] kib;
	kib = 24'd1024;
	// GSU carts always get 64 KiB
	if (mapper == 8'h20 && (typ == 8'h13 || typ == 8'h14 || typ == 8'h15 || typ == 8'h1A))
		return 24'h00FFFF;
	if (ras == 4'd0)
		return 24'd0;
	return (kib << ras) - 24'd1;
endfunction

function automatic logic [7:0] classify_header(input logic [1:0] layout,
		input logic [7:0] mapper, input logic [7:0] typ, input logic [3:0] rs,
		input logic [7:0] maker);
	logic [7:0] t;
	t = {6'd0, layout};
	if (mapper == 8'h30 && typ == 8'h05 && maker == 8'hB2)
		t[7:4] = 4'hA;
	else if (((mapper == 8'h20 || mapper == 8'h21) && typ == 8'h03)
			|| (mapper == 8'h30 && typ == 8'h05)
			|| (mapper == 8'h31 && (typ == 8'h03 || typ == 8'h05)))
		t[7] = 1'b1;
	else if (mapper == 8'h20 && typ == 8'h05)
		t[7:4] = 4'h9;
	else if (mapper == 8'h30 && typ == 8'h03)
		t[7:4] = 4'hB;
	else if (mapper == 8'h30 && typ == 8'h25)
		t[7:4] = 4'hC;
	else if (mapper == 8'h32 && (typ == 8'h43 || typ == 8'h45))
		t[7:4] = 4'h5;
	else if (mapper == 8'h30 && typ == 8'hF6) begin
		t[7:4] = 4'h8;
		t[3]   = 1'b1;
		if (rs < 4'd10)
			t[5] = 1'b1;
	end else if (mapper == 8'h20 && (typ == 8'h13 || typ == 8'h14 || typ == 8'h15
			|| typ == 8'h1A))
		t[7:4] = 4'h7;
	else if (mapper == 8'h23 && (typ == 8'h32 || typ == 8'h34 || typ == 8'h35))
		t[7:4] = 4'h6;
	return t;
endfunction

`endif

/* verif/tb_cart_subsystem.sv */
// Testbench for the cartridge subsystem with SD and backup memory models; run as the top module
`timescale 1ns/1ps
`default_nettype none

module tb_cart_subsystem;

	import cart_pkg::*;

	`include "tb_ref_model.svh"

	// Header length 512 in the low ten bits
	localparam logic [23:0] FILESIZE = 24'h100200;

	logic                clk_sys;
	logic                reset;
	logic                ioctl_download;
	logic                ioctl_wr;
	logic [24:0]         ioctl_addr;
	logic [15:0]         ioctl_dout;
	logic [23:0]         ioctl_filesize;
	rom_layout_t         rom_layout;
	logic                video_region;
	logic                img_mounted;
	logic [31:0]         img_size;
	logic                save_trigger;
	logic                sd_ack;
	logic [8:0]          sd_buff_addr;
	logic [7:0]          sd_buff_dout;
	logic                sd_buff_wr;
	logic                sd_buff_rd;
	logic [15:0]         bram_rdata = '0;
	wire                 rom_req;
	wire  [22:0]         rom_addr;
	wire  [15:0]         rom_data;
	wire  [7:0]          rom_type;
	wire  [23:0]         rom_mask;
	wire  [23:0]         ram_mask;
	wire                 pal;
	wire  [31:0]         sd_lba;
	wire                 sd_rd;
	wire                 sd_wr;
	wire  [7:0]          sd_buff_din;
	wire                 bram_req;
	wire  [18:0]         bram_addr;
	wire  [15:0]         bram_wdata;
	wire                 bram_we;
	wire                 halt;
	wire                 activity_led;

	int errors;
	int timeouts;
	int rom_words_sent;
	int rom_toggles;
	int bram_writes;

	logic [15:0] lfsr_q;
	logic        req_prev;
	logic        bram_req_seen;
	logic [22:0] exp_addr_q[$];
	logic [15:0] exp_data_q[$];
	logic [22:0] exp_addr;
	logic [15:0] exp_data;
	logic [7:0]  sd_bytes [0:1023];
	logic [15:0] save_ref [0:511];
	logic [15:0] mem      [0:1023];

	cart_subsystem_top #(
		.BRAM_ADDR_W(19)
	) u_cart_subsystem_top (
		.clk_sys(clk_sys), .reset(reset), .ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ioctl_filesize(ioctl_filesize), .rom_layout(rom_layout),
		.video_region(video_region), .img_mounted(img_mounted), .img_size(img_size),
		.save_trigger(save_trigger), .sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout), .sd_buff_wr(sd_buff_wr), .sd_buff_rd(sd_buff_rd),
		.bram_rdata(bram_rdata), .rom_req(rom_req), .rom_addr(rom_addr),
		.rom_data(rom_data), .rom_type(rom_type), .rom_mask(rom_mask),
		.ram_mask(ram_mask), .pal(pal), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.sd_buff_din(sd_buff_din), .bram_req(bram_req), .bram_addr(bram_addr),
		.bram_wdata(bram_wdata), .bram_we(bram_we), .halt(halt),
		.activity_led(activity_led)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			r      = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
		errors++;
	endtask

	// ==============================
	// ROM request checker
	// ==============================
	always @(posedge clk_sys) begin
		if (reset) begin
			req_prev <= 1'b0;
		end else if (rom_req !== req_prev) begin
			req_prev <= rom_req;
			rom_toggles++;
			if (exp_addr_q.size() == 0) begin
				$display("ROM request toggled with no word sent at %0t ns", $time);
				errors++;
			end else begin
				exp_addr = exp_addr_q.pop_front();
				exp_data = exp_data_q.pop_front();
				if (rom_addr !== exp_addr)
					report_mismatch("rom_addr", rom_addr, exp_addr);
				if (rom_data !== exp_data)
					report_mismatch("rom_data", rom_data, exp_data);
			end
		end
	end

	// Backup memory model, one access per request toggle
	always @(posedge clk_sys) begin
		if (reset) begin
			bram_req_seen <= 1'b0;
			bram_rdata    <= '0;
		end else if (bram_req !== bram_req_seen) begin
			bram_req_seen <= bram_req;
			if (bram_we) begin
				mem[bram_addr[9:0]] <= bram_wdata;
				bram_writes++;
			end else begin
				bram_rdata <= mem[bram_addr[9:0]];
			end
		end
	end

	task automatic send_word(input logic [24:0] a, input logic [15:0] d);
		@(posedge clk_sys);
		ioctl_addr <= a;
		ioctl_dout <= d;
		ioctl_wr   <= 1'b1;
		exp_addr_q.push_back(stripped_word_addr(a, FILESIZE));
		exp_data_q.push_back(d);
		rom_words_sent++;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic download_header(input logic [1:0] layout, input logic [7:0] mapper,
			input logic [7:0] typ, input logic [3:0] rs, input logic [3:0] ras,
			input logic [7:0] maker, input logic region);
		logic [24:0] base;
		logic [15:0] junk;
		logic [7:0]  exp_type;
		logic [23:0] exp_rom;
		logic [23:0] exp_ram;
		base = 25'h200 + {1'b0, header_window_base(layout)};
		junk = rand_bits(16);
		@(posedge clk_sys);
		rom_layout     <= rom_layout_t'(layout);
		video_region   <= region;
		ioctl_filesize <= FILESIZE;
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_sys);
		send_word(25'h200, junk);
		send_word(base + 25'h7FD4, {mapper, junk[7:0]});
		send_word(base + 25'h7FD6, {junk[3:0], rs, typ});
		send_word(base + 25'h7FD8, {junk[11:0], ras});
		send_word(base + 25'h7FDA, {junk[15:8], maker});
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_sys);
		exp_type = classify_header(layout, mapper, typ, rs, maker);
		exp_rom  = rom_mask_for_size(rs);
		exp_ram  = ram_mask_for_header(mapper, typ, ras);
		if (rom_type !== exp_type)
			report_mismatch("rom_type", rom_type, exp_type);
		if (rom_mask !== exp_rom)
			report_mismatch("rom_mask", rom_mask, exp_rom);
		if (ram_mask !== exp_ram)
			report_mismatch("ram_mask", ram_mask, exp_ram);
		if (pal !== region)
			report_mismatch("pal", pal, region);
	endtask

	task automatic chip_case(input logic [7:0] mapper, input logic [7:0] typ,
			input logic [3:0] rs, input logic [7:0] maker, input logic [3:0] exp_nib);
		download_header(2'(rand_bits(1)), mapper, typ, rs, 4'd3, maker, 1'b0);
		if (rom_type[7:4] !== exp_nib)
			report_mismatch("rom_type[7:4]", rom_type[7:4], exp_nib);
	endtask

	task automatic mount_image(input logic [31:0] size);
		@(posedge clk_sys);
		img_size    <= size;
		img_mounted <= 1'b1;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
	endtask

	// ==============================
	// SD card model
	// ==============================
	task automatic serve_sectors(input bit load, input int count);
		int          t;
		logic [7:0]  exp_b;
		logic [15:0] w;
		for (int s = 0; s < count; s++) begin
			t = 0;
			@(posedge clk_sys);
			while (!(load ? sd_rd : sd_wr) && t < 200) begin
				@(posedge clk_sys);
				t++;
			end
			if (t >= 200) begin
				$display("Timed out waiting for the SD request of sector %0d", s);
				timeouts++;
				return;
			end
			if (sd_lba !== 32'(s))
				report_mismatch("sd_lba", sd_lba, s);
			if (halt !== 1'b1)
				report_mismatch("halt", halt, 1'b1);
			repeat (2) @(posedge clk_sys);
			sd_ack <= 1'b1;
			for (int i = 0; i < 512; i++) begin
				@(posedge clk_sys);
				sd_buff_addr <= 9'(i);
				if (load) begin
					sd_buff_dout <= sd_bytes[s * 512 + i];
					sd_buff_wr   <= 1'b1;
				end else begin
					sd_buff_rd <= 1'b1;
				end
				@(posedge clk_sys);
				sd_buff_wr <= 1'b0;
				sd_buff_rd <= 1'b0;
				repeat (2) @(posedge clk_sys);
				if (!load) begin
					w     = save_ref[s * 256 + i / 2];
					exp_b = i[0] ? w[15:8] : w[7:0];
					if (sd_buff_din !== exp_b)
						report_mismatch("sd_buff_din", sd_buff_din, exp_b);
				end
			end
			// Requests are gone once the ack is seen, halt still high
			if ({halt, sd_rd, sd_wr} !== 3'b100)
				report_mismatch("{halt,sd_rd,sd_wr}", {halt, sd_rd, sd_wr}, 3'b100);
			@(posedge clk_sys);
			sd_ack <= 1'b0;
			t = 0;
			if (s == count - 1) begin
				@(posedge clk_sys);
				while (halt !== 1'b0 && t < 20) begin
					@(posedge clk_sys);
					t++;
				end
				if (halt !== 1'b0) begin
					$display("Timed out waiting for halt to fall after the last sector");
					timeouts++;
				end
			end else begin
				repeat (2) @(posedge clk_sys);
				if (halt !== 1'b1)
					report_mismatch("halt", halt, 1'b1);
			end
		end
	endtask

	// Save request must not start any SD transfer
	task automatic expect_no_transfer();
		@(posedge clk_sys);
		save_trigger <= 1'b1;
		@(posedge clk_sys);
		save_trigger <= 1'b0;
		for (int t = 0; t < 60; t++) begin
			@(posedge clk_sys);
			if (sd_wr || sd_rd) begin
				$display("SD transfer started with backup disabled at %0t ns", $time);
				errors++;
				break;
			end
		end
	endtask

	initial begin
		int t;
		errors = 0;
		timeouts = 0;
		rom_words_sent = 0;
		rom_toggles = 0;
		bram_writes = 0;
		lfsr_q = 16'd20914;
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_filesize = '0;
		rom_layout = LOROM;
		video_region = 1'b0;
		img_mounted = 1'b0;
		img_size = '0;
		save_trigger = 1'b0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		sd_buff_rd = 1'b0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		if (rom_req !== 1'b0)
			report_mismatch("rom_req", rom_req, 0);
		if ({sd_rd, sd_wr, halt} !== 3'b000)
			report_mismatch("{sd_rd,sd_wr,halt}", {sd_rd, sd_wr, halt}, 0);
		if (activity_led !== 1'b1)
			report_mismatch("activity_led", activity_led, 1);

		// Random headers for every layout
		for (int l = 0; l < 3; l++) begin
			for (int k = 0; k < 3; k++)
				download_header(2'(l), 8'h20 + 8'(rand_bits(5)), 8'(rand_bits(8)),
					4'(rand_bits(4)), 4'(rand_bits(4)), 8'(rand_bits(8)), 1'(rand_bits(1)));
		end

		// Directed chip rules
		chip_case(8'h30, 8'h05, 4'hB, 8'hB2, 4'hA);
		chip_case(8'h30, 8'h05, 4'hB, 8'h00, 4'h8);
		chip_case(8'h20, 8'h03, 4'hA, 8'h00, 4'h8);
		chip_case(8'h31, 8'h05, 4'hA, 8'h00, 4'h8);
		chip_case(8'h20, 8'h05, 4'hA, 8'h00, 4'h9);
		chip_case(8'h30, 8'h03, 4'hA, 8'h00, 4'hB);
		chip_case(8'h30, 8'h25, 4'hA, 8'h00, 4'hC);
		chip_case(8'h32, 8'h43, 4'hC, 8'h00, 4'h5);
		chip_case(8'h30, 8'hF6, 4'hB, 8'h00, 4'h8);
		chip_case(8'h30, 8'hF6, 4'h9, 8'h00, 4'hA);
		chip_case(8'h20, 8'h13, 4'h9, 8'h00, 4'h7);
		chip_case(8'h23, 8'h35, 4'hB, 8'h00, 4'h6);
		chip_case(8'h00, 8'h00, 4'hB, 8'h00, 4'h0);

		t = 0;
		while (exp_addr_q.size() != 0 && t < 20) begin
			@(posedge clk_sys);
			t++;
		end
		if (exp_addr_q.size() != 0) begin
			$display("Timed out waiting for the last ROM requests");
			timeouts++;
		end
		if (rom_toggles != rom_words_sent)
			report_mismatch("rom_req toggles", rom_toggles, rom_words_sent);

		// ==============================
		// Save RAM load and save
		// ==============================
		for (int i = 0; i < 1024; i++)
			sd_bytes[i] = 8'(rand_bits(8));
		bram_writes = 0;
		mount_image(32'd768);
		serve_sectors(1'b1, 2);
		if (bram_writes != 512)
			report_mismatch("backup writes", bram_writes, 512);
		for (int n = 0; n < 512; n++) begin
			if (mem[n] !== {sd_bytes[2 * n + 1], sd_bytes[2 * n]})
				report_mismatch("bram word", mem[n], {sd_bytes[2 * n + 1], sd_bytes[2 * n]});
		end
		if (activity_led !== 1'b0)
			report_mismatch("activity_led", activity_led, 0);

		for (int n = 0; n < 512; n++) begin
			save_ref[n] = 16'(rand_bits(16));
			mem[n]      = save_ref[n];
		end
		@(posedge clk_sys);
		save_trigger <= 1'b1;
		@(posedge clk_sys);
		save_trigger <= 1'b0;
		serve_sectors(1'b0, 2);

		// Backup off after an empty mount or a new download
		mount_image(32'd0);
		repeat (2) @(posedge clk_sys);
		if (activity_led !== 1'b1)
			report_mismatch("activity_led", activity_led, 1);
		expect_no_transfer();
		mount_image(32'd768);
		serve_sectors(1'b1, 2);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		repeat (3) @(posedge clk_sys);
		if (activity_led !== 1'b0)
			report_mismatch("activity_led", activity_led, 0);
		expect_no_transfer();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sys);
		if (activity_led !== 1'b1)
			report_mismatch("activity_led", activity_led, 1);

		$display("Value errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verif
common/cart_pkg.sv
cart/rom_load_port.sv
cart/header_detect.sv
backup/backup_sequencer.sv
logic/cart_subsystem_top.sv
verif/tb_cart_subsystem.sv
